// ==== Makefile ====
# Verilator build and run of the PE testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pe -o tb_pe_sim
	./obj_dir/tb_pe_sim | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== mac_control.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module mac_control (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_config,
  input  pe_pkg::pe_cfg_t        cfg,
  input  logic                   fpad_ready,
  input  logic                   wpad_ready,
  output logic [`PE_FPAD_AW:0]   conv_len,    // s*q
  output logic [`PE_WPAD_AW:0]   weight_num,  // s*q*p
  output logic [`PE_PPAD_AW:0]   filter_num,  // p
  output logic [`PE_FPAD_AW-1:0] fpad_addr,
  output logic [`PE_WPAD_AW-1:0] wpad_addr,
  output pe_pkg::mac_step_t      step
);

  logic [2*`PE_PARA_W-1:0] sq_prod;
  logic [3*`PE_PARA_W-1:0] sqp_prod;
  logic                    both_ready;
  logic                    both_ready_d;
  logic                    run_start;
  logic                    active;
  logic [`PE_FPAD_AW-1:0]  cnt_a;   // position inside one dot product
  logic [`PE_PPAD_AW-1:0]  cnt_b;   // filter
  logic [`PE_WPAD_AW-1:0]  w_base;  // cnt_b * conv_len, kept as a running sum
  logic                    last_a;
  logic                    last_b;

  assign sq_prod  = cfg.s * cfg.q;
  assign sqp_prod = sq_prod * cfg.p;

  // ------------------------------------------------------------
  // config register
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      conv_len   <= '0;
      weight_num <= '0;
      filter_num <= '0;
    end else if (start_config) begin
      conv_len   <= sq_prod[`PE_FPAD_AW:0];
      weight_num <= sqp_prod[`PE_WPAD_AW:0];
      filter_num <= cfg.p[`PE_PPAD_AW:0];
    end
  end

  // ------------------------------------------------------------
  // loop counters, one issue per cycle
  // ------------------------------------------------------------
  assign both_ready = fpad_ready & wpad_ready;
  assign run_start  = both_ready & ~both_ready_d;
  assign last_a     = ({1'b0, cnt_a} == conv_len - (`PE_FPAD_AW+1)'(1));
  assign last_b     = ({1'b0, cnt_b} == filter_num - (`PE_PPAD_AW+1)'(1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      both_ready_d <= 1'b0;
      active       <= 1'b0;
      cnt_a        <= '0;
      cnt_b        <= '0;
      w_base       <= '0;
    end else begin
      both_ready_d <= both_ready;
      if (run_start) begin
        active <= 1'b1;
        cnt_a  <= '0;
        cnt_b  <= '0;
        w_base <= '0;
      end else if (active) begin
        if (last_a) begin
          cnt_a  <= '0;
          cnt_b  <= cnt_b + `PE_PPAD_AW'(1);
          w_base <= w_base + `PE_WPAD_AW'(conv_len);  // next filter's weights
          if (last_b) active <= 1'b0;
        end else begin
          cnt_a <= cnt_a + `PE_FPAD_AW'(1);
        end
      end
    end
  end

  assign fpad_addr = cnt_a;
  assign wpad_addr = w_base + `PE_WPAD_AW'(cnt_a);

  always_comb begin
    step.valid      = active;
    step.first      = active && (cnt_a == '0);
    step.last       = active && last_a;
    step.final_step = active && last_a && last_b;
    step.idx        = cnt_b;
  end

  // pads must hold still and config must not move under a run
  a_run_stable: assert property (@(posedge clk) disable iff (rst)
    active |-> (fpad_ready && wpad_ready && !start_config));

endmodule

// ==== mac_unit.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module mac_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  pe_pkg::mac_step_t     step,
  input  logic [`PE_DATA_W-1:0] fmap_data,
  input  logic [`PE_DATA_W-1:0] weight_data,
  output pe_pkg::psum_store_t   store
);

  localparam int PROD_W = 2 * `PE_DATA_W;

  pe_pkg::mac_step_t            rd_step;   // aligned with pad read data
  pe_pkg::mac_step_t            mul_step;  // aligned with prod
  logic signed [PROD_W-1:0]     prod;
  logic signed [`PE_PSUM_W-1:0] prod_ext;
  logic signed [`PE_PSUM_W-1:0] acc;
  logic signed [`PE_PSUM_W-1:0] acc_next;

  // ------------------------------------------------------------
  // tag pipeline and store register
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_step  <= '0;
      mul_step <= '0;
      store    <= '0;
    end else begin
      rd_step          <= step;
      mul_step         <= rd_step;
      store.en         <= mul_step.valid && mul_step.last;
      store.final_step <= mul_step.valid && mul_step.final_step;
      store.idx        <= mul_step.idx;
      store.psum       <= acc_next;
    end
  end

  // sign extend product to psum width
  assign prod_ext = {{(`PE_PSUM_W-PROD_W){prod[PROD_W-1]}}, prod};

  // first step of each filter starts a fresh sum
  assign acc_next = mul_step.first ? prod_ext : acc + prod_ext;

  always_ff @(posedge clk) begin
    prod <= $signed(fmap_data) * $signed(weight_data);
    if (mul_step.valid) acc <= acc_next;
  end

endmodule

// ==== pe_defines.svh ====
`ifndef PE_DEFINES_SVH
`define PE_DEFINES_SVH

// ------------------------------------------------------------
// word widths
// ------------------------------------------------------------
`define PE_DATA_W 16  // feature and weight words
`define PE_PSUM_W 40
`define PE_PARA_W 8   // s, q and p fields

// ------------------------------------------------------------
// pad sizes
// ------------------------------------------------------------
`define PE_FPAD_DEPTH 36
`define PE_FPAD_AW    6
`define PE_WPAD_DEPTH 200
`define PE_WPAD_AW    8
`define PE_PPAD_DEPTH 32  // one psum per filter
`define PE_PPAD_AW    5

`endif

// ==== pe_pkg.sv ====
`include "pe_defines.svh"

package pe_pkg;

  // captured on start_config
  typedef struct packed {
    logic [`PE_PARA_W-1:0] s;  // filter size
    logic [`PE_PARA_W-1:0] q;  // channel count
    logic [`PE_PARA_W-1:0] p;  // filter count
  } pe_cfg_t;

  // one beat of a load stream
  typedef struct packed {
    logic                  en;
    logic [`PE_DATA_W-1:0] data;
  } data_beat_t;

  // one beat of the psum readout
  typedef struct packed {
    logic                  en;
    logic [`PE_PSUM_W-1:0] data;
  } psum_beat_t;

  // tag that follows each pad read down the mac pipeline
  typedef struct packed {
    logic                   valid;
    logic                   first;       // a == 0, restart the sum
    logic                   last;        // a == conv_len-1, emit
    logic                   final_step;  // last step of the last filter
    logic [`PE_PPAD_AW-1:0] idx;         // filter b
  } mac_step_t;

  typedef struct packed {
    logic                   en;
    logic                   final_step;
    logic [`PE_PPAD_AW-1:0] idx;
    logic [`PE_PSUM_W-1:0]  psum;
  } psum_store_t;

endpackage

// ==== pe_top.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module pe_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               start_config,
  input  pe_pkg::pe_cfg_t    cfg,
  input  logic               start_weight_load,
  input  logic               start_feature_load,
  input  pe_pkg::data_beat_t weight_in,
  input  pe_pkg::data_beat_t feature_in,
  input  logic               start_psum_out,
  output logic               mac_finish,
  output logic               psum_ready,
  output pe_pkg::psum_beat_t psum_out
);

  logic [`PE_FPAD_AW:0]   conv_len;
  logic [`PE_WPAD_AW:0]   weight_num;
  logic [`PE_PPAD_AW:0]   filter_num;
  logic [`PE_FPAD_AW-1:0] fpad_addr;
  logic [`PE_WPAD_AW-1:0] wpad_addr;
  logic [`PE_DATA_W-1:0]  fmap_data;
  logic [`PE_DATA_W-1:0]  weight_data;
  logic                   fpad_ready;
  logic                   wpad_ready;
  pe_pkg::mac_step_t      step;
  pe_pkg::psum_store_t    store;

  // ------------------------------------------------------------
  // control and the two pads
  // ------------------------------------------------------------
  mac_control i_mac_control (
    .clk, .rst, .start_config, .cfg, .fpad_ready, .wpad_ready,
    .conv_len, .weight_num, .filter_num, .fpad_addr, .wpad_addr, .step
  );

  scratch_pad #(.DEPTH(`PE_FPAD_DEPTH), .AW(`PE_FPAD_AW)) fpad (
    .clk, .rst, .load_start(start_feature_load), .fill_count(conv_len),
    .wr(feature_in), .rd_addr(fpad_addr), .rd_data(fmap_data), .ready(fpad_ready)
  );

  scratch_pad #(.DEPTH(`PE_WPAD_DEPTH), .AW(`PE_WPAD_AW)) wpad (
    .clk, .rst, .load_start(start_weight_load), .fill_count(weight_num),
    .wr(weight_in), .rd_addr(wpad_addr), .rd_data(weight_data), .ready(wpad_ready)
  );

  // ------------------------------------------------------------
  // datapath and result storage
  // ------------------------------------------------------------
  mac_unit i_mac_unit (
    .clk, .rst, .step, .fmap_data, .weight_data, .store
  );

  psum_pad i_psum_pad (
    .clk, .rst, .store, .filter_num, .start_psum_out,
    .mac_finish, .psum_ready, .psum_out
  );

endmodule

// ==== psum_pad.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module psum_pad (
  input  logic                  clk,
  input  logic                  rst,
  input  pe_pkg::psum_store_t   store,
  input  logic [`PE_PPAD_AW:0]  filter_num,
  input  logic                  start_psum_out,
  output logic                  mac_finish,
  output logic                  psum_ready,
  output pe_pkg::psum_beat_t    psum_out
);

  logic [`PE_PSUM_W-1:0]  mem [`PE_PPAD_DEPTH];
  logic                   reading;
  logic [`PE_PPAD_AW:0]   rd_cnt;    // next filter to send
  logic                   accept;
  logic                   rd_done;
  logic                   send;
  logic [`PE_PPAD_AW-1:0] send_idx;
  logic                   run_done;

  assign run_done = store.en && store.final_step;

  always_ff @(posedge clk) begin
    if (store.en) mem[store.idx] <= store.psum;
  end

  // ------------------------------------------------------------
  // readout, filter 0 first
  // ------------------------------------------------------------
  assign accept   = start_psum_out && psum_ready && !reading;  // else ignored
  assign rd_done  = reading && (rd_cnt == filter_num);
  assign send     = accept || (reading && !rd_done);
  assign send_idx = accept ? '0 : rd_cnt[`PE_PPAD_AW-1:0];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mac_finish <= 1'b0;
      psum_ready <= 1'b0;
      reading    <= 1'b0;
      rd_cnt     <= '0;
      psum_out   <= '0;
    end else begin
      mac_finish <= run_done;  // one cycle pulse
      if (run_done) begin
        psum_ready <= 1'b1;
      end else if (rd_done) begin
        psum_ready <= 1'b0;
      end

      if (accept) begin
        reading <= 1'b1;
        rd_cnt  <= (`PE_PPAD_AW+1)'(1);  // beat 0 goes out now
      end else if (rd_done) begin
        reading <= 1'b0;
      end else if (reading) begin
        rd_cnt <= rd_cnt + (`PE_PPAD_AW+1)'(1);
      end

      psum_out.en   <= send;
      psum_out.data <= send ? mem[send_idx] : '0;
    end
  end

  // filter index from the control loop must fit the configured count
  a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
    store.en |-> ({1'b0, store.idx} < filter_num));

endmodule

// ==== scratch_pad.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module scratch_pad #(
  parameter int DEPTH = `PE_FPAD_DEPTH,
  parameter int AW    = `PE_FPAD_AW
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load_start,
  input  logic [AW:0]            fill_count,  // words expected per load
  input  pe_pkg::data_beat_t     wr,
  input  logic [AW-1:0]          rd_addr,
  output logic [`PE_DATA_W-1:0]  rd_data,
  output logic                   ready
);

  logic [`PE_DATA_W-1:0] mem [DEPTH];
  logic [AW:0]           wr_cnt;
  logic                  loading;
  logic                  full;
  logic                  wr_fire;

  assign full    = (wr_cnt == fill_count);
  assign wr_fire = wr.en && loading && !full && !load_start;

  // ------------------------------------------------------------
  // load counter and ready level
  // ------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_cnt  <= '0;
      loading <= 1'b0;
      ready   <= 1'b0;
    end else if (load_start) begin
      wr_cnt  <= '0;  // restart at address 0
      loading <= 1'b1;
      ready   <= 1'b0;
    end else begin
      if (wr_fire) wr_cnt <= wr_cnt + (AW+1)'(1);
      if (loading && full) begin
        loading <= 1'b0;
        ready   <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) mem[wr_cnt[AW-1:0]] <= wr.data;
    rd_data <= mem[rd_addr];  // one cycle read
  end

  // extra beats past the configured fill count would be lost
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    ((loading || ready) && full && !load_start) |-> !wr.en);

endmodule

// ==== sim.f ====
+incdir+.
pe_pkg.sv
scratch_pad.sv
mac_control.sv
mac_unit.sv
psum_pad.sv
pe_top.sv
tb_pe.sv

// ==== tb_pe.sv ====
`timescale 1ns/1ps
`include "pe_defines.svh"

module tb_pe;

  localparam int N_TESTS = 4;
  // worst case load, run, readout plus idle gaps between phases
  localparam int TEST_CYCLES = `PE_FPAD_DEPTH + `PE_WPAD_DEPTH + `PE_WPAD_DEPTH + 3
                             + `PE_PPAD_DEPTH + 40;
  localparam int WATCHDOG_CYCLES = N_TESTS * TEST_CYCLES * 2;

  logic               clk;
  logic               rst;
  logic               start_config;
  pe_pkg::pe_cfg_t    cfg;
  logic               start_weight_load;
  logic               start_feature_load;
  pe_pkg::data_beat_t weight_in;
  pe_pkg::data_beat_t feature_in;
  logic               start_psum_out;
  logic               mac_finish;
  logic               psum_ready;
  pe_pkg::psum_beat_t psum_out;

  integer                       seed;
  logic signed [`PE_DATA_W-1:0] f_mem [`PE_FPAD_DEPTH];
  logic signed [`PE_DATA_W-1:0] w_mem [`PE_WPAD_DEPTH];
  logic signed [`PE_PSUM_W-1:0] exp_psum [`PE_PPAD_DEPTH];  // model result per filter
  int   cur_len;
  int   cur_p;
  int   err_cnt = 0;  // bumped by the assertions
  int   tmo_cnt = 0;
  int   finish_cnt;
  int   finish_base = 0;
  logic loaded_once = 1'b0;
  int   beat_left;  // readout beats still due
  int   beat_idx;

  pe_top i_pe_top (
    .clk, .rst, .start_config, .cfg, .start_weight_load, .start_feature_load,
    .weight_in, .feature_in, .start_psum_out, .mac_finish, .psum_ready, .psum_out
  );

  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // expected readout window and finish count
  // ------------------------------------------------------------
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      beat_left  <= 0;
      beat_idx   <= 0;
      finish_cnt <= 0;
    end else begin
      if (mac_finish) finish_cnt <= finish_cnt + 1;
      if (beat_left != 0) begin
        beat_left <= beat_left - 1;
        beat_idx  <= beat_idx + 1;
      end else if (start_psum_out && psum_ready) begin
        beat_left <= cur_p;  // accepted request
        beat_idx  <= 0;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !loaded_once |-> (!mac_finish && !psum_ready && !psum_out.en))
    else begin
      $display("error %0t: mac_finish,psum_ready,psum_out.en expected 000 actual %b%b%b",
               $time, $sampled(mac_finish), $sampled(psum_ready), $sampled(psum_out.en));
      err_cnt++;
    end

  a_one_finish: assert property (@(posedge clk) disable iff (rst)
    mac_finish |-> (finish_cnt == finish_base))
    else begin
      $display("mac_finish pulsed more than once in one run at %0t", $time);
      err_cnt++;
    end

  a_finish_ready: assert property (@(posedge clk) disable iff (rst)
    mac_finish |-> psum_ready)
    else begin
      $display("error %0t: psum_ready expected 1 actual 0", $time);
      err_cnt++;
    end

  a_ready_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(psum_ready) |-> mac_finish)
    else begin
      $display("error %0t: mac_finish expected 1 actual 0", $time);
      err_cnt++;
    end

  a_beat_en: assert property (@(posedge clk) disable iff (rst)
    psum_out.en == (beat_left != 0))
    else begin
      $display("error %0t: psum_out.en expected %b actual %b",
               $time, ($sampled(beat_left) != 0), $sampled(psum_out.en));
      err_cnt++;
    end

  a_beat_data: assert property (@(posedge clk) disable iff (rst)
    (beat_left != 0) |-> (psum_out.data == exp_psum[beat_idx]))
    else begin
      $display("error %0t: psum_out.data (filter %0d) expected %0d actual %0d", $time,
               $sampled(beat_idx), exp_psum[$sampled(beat_idx)],
               $signed($sampled(psum_out.data)));
      err_cnt++;
    end

  a_ready_cleared: assert property (@(posedge clk) disable iff (rst)
    (beat_left == 1) |=> !psum_ready)
    else begin
      $display("error %0t: psum_ready expected 0 actual 1", $time);
      err_cnt++;
    end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------
  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;  // inputs move just after the edge
  endtask

  // random config and data, then the expected psums
  task automatic make_test_data(output pe_pkg::pe_cfg_t c);
    int s;
    int q;
    int p_max;
    int a;
    int b;
    logic signed [`PE_PSUM_W-1:0] acc;
    s     = 1 + rand_below(6);
    q     = 1 + rand_below(6);  // s*q stays within the feature pad
    p_max = `PE_WPAD_DEPTH / (s * q);
    if (p_max > `PE_PPAD_DEPTH) p_max = `PE_PPAD_DEPTH;
    cur_len = s * q;
    cur_p   = 1 + rand_below(p_max);
    c.s = 8'(s);
    c.q = 8'(q);
    c.p = 8'(cur_p);
    for (a = 0; a < cur_len; a++) f_mem[a] = 16'($random(seed));
    for (a = 0; a < cur_len * cur_p; a++) w_mem[a] = 16'($random(seed));
    for (b = 0; b < cur_p; b++) begin
      acc = '0;
      for (a = 0; a < cur_len; a++)
        acc = acc + 40'(f_mem[a]) * 40'(w_mem[b * cur_len + a]);
      exp_psum[b] = acc;
    end
  endtask

  task automatic stream_features();
    int i;
    for (i = 0; i < cur_len; i++) begin
      feature_in.en   = 1'b1;
      feature_in.data = f_mem[i];
      next_cycle();
    end
    feature_in = '0;
  endtask

  task automatic stream_weights();
    int i;
    for (i = 0; i < cur_len * cur_p; i++) begin
      weight_in.en   = 1'b1;
      weight_in.data = w_mem[i];
      next_cycle();
    end
    weight_in = '0;
  endtask

  task automatic pulse_psum_out();
    start_psum_out = 1'b1;
    next_cycle();
    start_psum_out = 1'b0;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    pe_pkg::pe_cfg_t c;
    int t;
    int limit;
    int err_mark;
    int tmo_mark;
    int pass_tests;
    int fail_tests;
    seed               = 32'hcd4464f8;
    pass_tests         = 0;
    fail_tests         = 0;
    clk                = 1'b0;
    rst                = 1'b1;
    start_config       = 1'b0;
    cfg                = '0;
    start_weight_load  = 1'b0;
    start_feature_load = 1'b0;
    weight_in          = '0;
    feature_in         = '0;
    start_psum_out     = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;
    next_cycle();

    for (t = 0; t < N_TESTS; t++) begin
      err_mark    = err_cnt;
      tmo_mark    = tmo_cnt;
      finish_base = finish_cnt;
      make_test_data(c);
      cfg          = c;
      start_config = 1'b1;
      next_cycle();
      start_config = 1'b0;
      // both pads cleared before either fills, stray readout request with ready low
      start_feature_load = 1'b1;
      start_weight_load  = 1'b1;
      start_psum_out     = 1'b1;
      next_cycle();
      start_feature_load = 1'b0;
      start_weight_load  = 1'b0;
      start_psum_out     = 1'b0;
      if (rand_below(2) == 0) begin
        stream_features();
        stream_weights();
      end else begin
        stream_weights();
        stream_features();
      end
      loaded_once = 1'b1;

      limit = cur_len * cur_p + 10;
      while (!mac_finish && limit > 0) begin
        next_cycle();
        limit--;
      end
      if (!mac_finish) begin
        $display("test %0d: mac_finish never came after the pads were loaded", t);
        tmo_cnt++;
      end

      repeat (rand_below(4)) next_cycle();
      pulse_psum_out();
      limit = cur_p + 5;
      while (psum_ready && limit > 0) begin
        next_cycle();
        limit--;
      end
      if (psum_ready) begin
        $display("test %0d: psum_ready stayed high after the readout", t);
        tmo_cnt++;
      end
      repeat (3) next_cycle();
      pulse_psum_out();  // ready is low again, must be ignored
      repeat (3) next_cycle();

      if (err_cnt == err_mark && tmo_cnt == tmo_mark) begin
        pass_tests++;
        $display("test %0d s=%0d q=%0d p=%0d passed", t, c.s, c.q, c.p);
      end else begin
        fail_tests++;
        $display("test %0d s=%0d q=%0d p=%0d failed", t, c.s, c.q, c.p);
      end
    end

    $display("tests passed %0d failed %0d, check errors %0d", pass_tests, fail_tests,
             err_cnt);
    if (fail_tests == 0 && err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule
